/* logic/requant_pkg.sv */
package requant_pkg;

  //////////////////////////////////////////////////////////////////////
  // array geometry
  //////////////////////////////////////////////////////////////////////

  // columns of the systolic array
  localparam int COLS_IN_SA   = 4;
  // parallel pixels per pe
  localparam int PIX_PAR      = 2;
  // channels carried in one sum bus (mode 1)
  localparam int N_CH         = 2;
  // lanes of one channel
  localparam int LANES_PER_CH = COLS_IN_SA * PIX_PAR;
  // all multiplier lanes
  localparam int N_LANES      = N_CH * LANES_PER_CH;

  //////////////////////////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////////////////////////

  // wide sum, 8x8 precision
  localparam int SUM_W_88  = 24;
  // narrow sum, 1x8 precision
  localparam int SUM_W_18  = 16;
  // whole sum bus, sized for the narrow mode
  localparam int SUM_BUS_W = N_LANES * SUM_W_18;
  // bits used by a mode 0 vector, low end of the bus
  localparam int SUM_88_W  = LANES_PER_CH * SUM_W_88;

  // one scale tail
  localparam int E_W       = 16;

  // multiplier ports
  localparam int MULT_A_W  = 24;
  localparam int MULT_B_W  = 16;
  localparam int MULT_P_W  = 40;
  // product plus rounding term needs one more bit
  localparam int RND_W     = MULT_P_W + 1;

  // output pixel and its rails
  localparam int PIX_OUT_W = 8;
  localparam int PIX_MAX   = 127;
  localparam int PIX_MIN   = -128;

  // right shift amount, 0..31
  localparam int SHIFT_W   = 5;

  //////////////////////////////////////////////////////////////////////
  // mode codes
  //////////////////////////////////////////////////////////////////////

  localparam int MODE_W = 4;
  // one 24-bit channel
  localparam logic [MODE_W-1:0] MODE_88 = 4'd0;
  // two 16-bit channels, one tail each
  localparam logic [MODE_W-1:0] MODE_18 = 4'd1;

  //////////////////////////////////////////////////////////////////////
  // pipeline words
  //////////////////////////////////////////////////////////////////////

  // input word from the accumulators
  // e_set[0] serves mode 0 and channel 0 of mode 1
  typedef struct packed {
    logic [MODE_W-1:0]        mode;
    logic [N_CH-1:0][E_W-1:0] e_set;
    logic [SUM_BUS_W-1:0]     sum_vector;
    logic [SHIFT_W-1:0]       shift;
  } req_in_t;

  // multiplier operands, one a/b pair per lane
  typedef struct packed {
    logic [N_LANES-1:0][MULT_A_W-1:0] a;
    logic [N_LANES-1:0][MULT_B_W-1:0] b;
    logic [SHIFT_W-1:0]               shift;
  } mult_op_t;

  // signed products, shift rides along
  typedef struct packed {
    logic [N_LANES-1:0][MULT_P_W-1:0] p;
    logic [SHIFT_W-1:0]               shift;
  } mult_res_t;

  // int8 pixels, lane 0 in the low byte
  typedef struct packed {
    logic [N_LANES-1:0][PIX_OUT_W-1:0] pix;
  } pix_out_t;

endpackage

/* logic/requant_top.sv */
module requant_top
  import requant_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  req_in_t  in_data,
  output logic     out_valid,
  output pix_out_t out_data
);

  //////////////////////////////////////////////////////////////////////
  // stage links
  //////////////////////////////////////////////////////////////////////

  // packer -> multipliers, same cycle as in_valid
  mult_op_t  mult_ops;
  // multipliers -> round/clip, one cycle later
  logic      mult_valid;
  mult_res_t mult_res;

  // stage 0, combinational lane formatting
  scale_operand_pack scale_operand_pack_inst (
    .op_in  (in_data),
    .op_out (mult_ops)
  );

  // stage 1, registered products
  scale_mult_array scale_mult_array_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_valid  (in_valid),
    .ops       (mult_ops),
    .res_valid (mult_valid),
    .res       (mult_res)
  );

  // stage 2, registered int8 pixels
  // out_valid lands two clocks after in_valid
  scale_round_clip scale_round_clip_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .res_valid (mult_valid),
    .res       (mult_res),
    .out_valid (out_valid),
    .pixel_out (out_data)
  );

endmodule

/* logic/scale_mult_array.sv */
module scale_mult_array
  import requant_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      op_valid,
  input  mult_op_t  ops,
  output logic      res_valid,
  output mult_res_t res
);

  //////////////////////////////////////////////////////////////////////
  // lane multipliers
  //////////////////////////////////////////////////////////////////////

  // next product word
  mult_res_t res_nxt;

  always_comb begin
    res_nxt.shift = ops.shift;
    for (int i = 0; i < N_LANES; i++) begin
      // signed a times unsigned b
      // b gets a zero msb so it multiplies as a positive value
      // both operands widen to MULT_P_W before the multiply
      res_nxt.p[i] = $signed(ops.a[i]) * $signed({1'b0, ops.b[i]});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // payload, loads only on a valid operand word
  always_ff @(posedge clk) begin
    if (op_valid) begin
      res <= res_nxt;
    end
  end

  // valid strobe, one cycle behind op_valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= op_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // strobe must stay clean once out of reset
  // an x here would smear into the round/clip valid as well
  a_res_valid_known : assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(res_valid)
  );

endmodule

/* logic/scale_operand_pack.sv */
module scale_operand_pack
  import requant_pkg::*;
(
  input  req_in_t  op_in,
  output mult_op_t op_out
);

  //////////////////////////////////////////////////////////////////////
  // views of the sum bus
  //////////////////////////////////////////////////////////////////////

  // mode 0 view, eight 24-bit sums in the low 192 bits
  logic [LANES_PER_CH-1:0][SUM_W_88-1:0] sum_88;
  // mode 1 view, sixteen 16-bit sums
  // lanes 0..7 channel 0, lanes 8..15 channel 1
  logic [N_LANES-1:0][SUM_W_18-1:0]      sum_18;

  // scale tails
  logic [E_W-1:0] e_lo;
  logic [E_W-1:0] e_hi;

  assign sum_88 = op_in.sum_vector[SUM_88_W-1:0];
  assign sum_18 = op_in.sum_vector;

  // low tail shared by mode 0 and channel 0
  assign e_lo = op_in.e_set[0];
  assign e_hi = op_in.e_set[1];

  //////////////////////////////////////////////////////////////////////
  // lane formatting
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // idle lanes and unknown modes see zero operands
    op_out       = '0;
    op_out.shift = op_in.shift;

    case (op_in.mode)
      MODE_88: begin
        for (int i = 0; i < LANES_PER_CH; i++) begin
          // sum already at full a width
          op_out.a[i] = MULT_A_W'(sum_88[i]);
          // tail is unsigned, zero-extend
          op_out.b[i] = MULT_B_W'(e_lo);
        end
        // upper lanes stay zero
      end

      MODE_18: begin
        for (int i = 0; i < LANES_PER_CH; i++) begin
          // channel 0, sign-extend 16 -> 24
          op_out.a[i] = MULT_A_W'($signed(sum_18[i]));
          op_out.b[i] = MULT_B_W'(e_lo);

          // channel 1 on the upper half
          op_out.a[LANES_PER_CH + i] = MULT_A_W'($signed(sum_18[LANES_PER_CH + i]));
          op_out.b[LANES_PER_CH + i] = MULT_B_W'(e_hi);
        end
      end

      default: begin
        // reserved mode codes, everything zeroed above
      end
    endcase
  end

endmodule

/* logic/scale_round_clip.sv */
module scale_round_clip
  import requant_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      res_valid,
  input  mult_res_t res,
  output logic      out_valid,
  output pix_out_t  pixel_out
);

  //////////////////////////////////////////////////////////////////////
  // round, shift, saturate
  //////////////////////////////////////////////////////////////////////

  // product plus half lsb, one guard bit
  logic signed [RND_W-1:0] rnd_sum [N_LANES];
  // after the arithmetic shift
  logic signed [RND_W-1:0] shifted [N_LANES];
  // next pixel word
  pix_out_t                pix_nxt;

  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      rnd_sum[i] = RND_W'($signed(res.p[i]));
      // round half up, no term for shift 0
      if (res.shift != '0) begin
        rnd_sum[i] = rnd_sum[i] + (RND_W'(1) << (res.shift - 1'b1));
      end

      shifted[i] = rnd_sum[i] >>> res.shift;

      // clip to the int8 rails
      if (shifted[i] > PIX_MAX) begin
        pix_nxt.pix[i] = PIX_OUT_W'(PIX_MAX);
      end else if (shifted[i] < PIX_MIN) begin
        pix_nxt.pix[i] = PIX_OUT_W'(PIX_MIN);
      end else begin
        pix_nxt.pix[i] = shifted[i][PIX_OUT_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (res_valid) begin
      pixel_out <= pix_nxt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= res_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // one output strobe per product strobe, one cycle later
  a_valid_latency : assert property (
    @(posedge clk) disable iff (!arst_n)
    res_valid |=> out_valid
  );
  a_no_extra_valid : assert property (
    @(posedge clk) disable iff (!arst_n)
    !res_valid |=> !out_valid
  );

  // pixel keeps the sign of its product
  // a negative product may round up to zero but never above
  // a wrapped value instead of a rail would flip the sign
  for (genvar g = 0; g < N_LANES; g++) begin : g_clip_chk
    a_pix_sign : assert property (
      @(posedge clk) disable iff (!arst_n)
      out_valid |-> ($past(res.p[g][MULT_P_W-1]) ?
                     (pixel_out.pix[g][PIX_OUT_W-1] || pixel_out.pix[g] == '0) :
                     !pixel_out.pix[g][PIX_OUT_W-1])
    );
  end

endmodule

/* requant.f */
logic/requant_pkg.sv
logic/scale_operand_pack.sv
logic/scale_mult_array.sv
logic/scale_round_clip.sv
logic/requant_top.sv
verif/requant_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the requantization testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module requant_tb \
  -f requant.f \
  -o requant_sim

./obj_dir/requant_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* verif/requant_tb.sv */
module requant_tb
  import requant_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // run limits and stimulus codes
  //////////////////////////////////////////////////////////////////////

  localparam int RESET_CYCLES   = 16;
  localparam int N_ROWS         = 12;
  // every row fits in 3 cycles even with gaps, plus drain margin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ROWS * 3 + 50;
  // in_valid to out_valid
  localparam int PIPE_LAT       = 2;

  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED = 32'd5;

  // sum patterns
  localparam logic [2:0] PAT_RAND = 3'd0;
  localparam logic [2:0] PAT_MAX  = 3'd1;
  localparam logic [2:0] PAT_MIN  = 3'd2;
  localparam logic [2:0] PAT_MIX  = 3'd3;
  localparam logic [2:0] PAT_HALF = 3'd4;

  // one stimulus row
  typedef struct packed {
    logic [MODE_W-1:0]  mode;
    logic [E_W-1:0]     e_hi;
    logic [E_W-1:0]     e_lo;
    logic [SHIFT_W-1:0] shift;
    logic [2:0]         pat;
    logic [1:0]         gap;
  } row_t;

  //////////////////////////////////////////////////////////////////////
  // dut and clock
  //////////////////////////////////////////////////////////////////////

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  req_in_t  in_data;
  logic     out_valid;
  pix_out_t out_data;

  requant_top requant_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // scoreboard state
  row_t        stim_table [N_ROWS];
  pix_out_t    exp_q [$];
  int          row_q [$];
  int          issue_q [$];
  longint      lane_vals [N_LANES];
  logic [31:0] lfsr_state = LFSR_SEED;
  int          cycle_count = 0;
  int          errors = 0;
  int          rows_checked = 0;
  int          lanes_checked = 0;

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit drawn
  function automatic longint random_bits(input int width);
    longint v;
    v = 0;
    for (int i = 0; i < width; i++) begin
      v = (v << 1) | longint'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // signed sum for one lane of a given width
  function automatic longint pattern_value(input logic [2:0] pat, input int lane,
                                           input int width);
    longint top;
    longint raw;
    top = longint'(1) << (width - 1);
    case (pat)
      PAT_MAX:  return top - 1;
      PAT_MIN:  return -top;
      // odd lanes negative, magnitudes grow with the lane
      PAT_MIX:  return lane[0] ? -longint'((lane + 1) * 53) : longint'((lane + 1) * 37);
      // odd values, x.5 after a shift of one
      PAT_HALF: return lane[0] ? -longint'(2 * lane + 1) : longint'(2 * lane + 1);
      default: begin
        raw = random_bits(width);
        // msb of the draw is the sign
        return (raw >= top) ? raw - 2 * top : raw;
      end
    endcase
  endfunction

  // fills lane_vals and the packed sum bus for one row
  task automatic build_vector(input row_t row, output logic [SUM_BUS_W-1:0] vec);
    int     w;
    int     n;
    longint v;
    w = (row.mode == MODE_88) ? SUM_W_88 : SUM_W_18;
    n = (row.mode == MODE_88) ? LANES_PER_CH : N_LANES;
    // ones above a mode 0 vector, must be ignored
    vec = '1;
    for (int i = 0; i < N_LANES; i++) begin
      lane_vals[i] = 0;
    end
    for (int i = 0; i < n; i++) begin
      v = pattern_value(row.pat, i, w);
      lane_vals[i] = v;
      if (row.mode == MODE_88) begin
        vec[i*SUM_W_88 +: SUM_W_88] = v[SUM_W_88-1:0];
      end else begin
        vec[i*SUM_W_18 +: SUM_W_18] = v[SUM_W_18-1:0];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // multiply, round half up, arithmetic shift, clip to int8
  function automatic logic [PIX_OUT_W-1:0] requant_lane(input longint sum, input longint e,
                                                        input int shift);
    longint acc;
    acc = sum * e;
    if (shift > 0) begin
      acc = acc + (longint'(1) << (shift - 1));
    end
    acc = acc >>> shift;
    if (acc > 127) begin
      acc = 127;
    end else if (acc < -128) begin
      acc = -128;
    end
    return acc[PIX_OUT_W-1:0];
  endfunction

  function automatic pix_out_t expect_pixels(input row_t row);
    pix_out_t want;
    longint   e;
    want = '0;
    for (int i = 0; i < N_LANES; i++) begin
      // tail per lane, zero where the mode leaves the lane idle
      if (row.mode == MODE_88 && i < LANES_PER_CH) begin
        e = longint'(row.e_lo);
      end else if (row.mode == MODE_18) begin
        e = (i < LANES_PER_CH) ? longint'(row.e_lo) : longint'(row.e_hi);
      end else begin
        e = 0;
      end
      want.pix[i] = requant_lane(lane_vals[i], e, int'(row.shift));
    end
    return want;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic load_table();
    //                mode     e_hi      e_lo      shift  pattern   gap
    stim_table[0]  = '{MODE_88, 16'h0000, 16'h0001, 5'd8,  PAT_RAND, 2'd0};
    stim_table[1]  = '{MODE_88, 16'h7777, 16'h00c8, 5'd24, PAT_RAND, 2'd0};
    stim_table[2]  = '{MODE_18, 16'h0011, 16'h0300, 5'd10, PAT_MIX,  2'd0};
    stim_table[3]  = '{MODE_18, 16'h1234, 16'h00a5, 5'd16, PAT_RAND, 2'd0};
    stim_table[4]  = '{MODE_18, 16'hffff, 16'hffff, 5'd2,  PAT_MAX,  2'd1};
    stim_table[5]  = '{MODE_18, 16'hffff, 16'hffff, 5'd2,  PAT_MIN,  2'd0};
    stim_table[6]  = '{MODE_88, 16'h0000, 16'hffff, 5'd3,  PAT_MAX,  2'd0};
    stim_table[7]  = '{MODE_88, 16'h0000, 16'hffff, 5'd3,  PAT_MIN,  2'd0};
    stim_table[8]  = '{MODE_18, 16'h0001, 16'h0001, 5'd0,  PAT_HALF, 2'd2};
    stim_table[9]  = '{MODE_18, 16'h0001, 16'h0001, 5'd1,  PAT_HALF, 2'd0};
    stim_table[10] = '{MODE_88, 16'h0000, 16'h0001, 5'd1,  PAT_HALF, 2'd0};
    // reserved mode code
    stim_table[11] = '{4'd5,    16'hbeef, 16'h1357, 5'd4,  PAT_RAND, 2'd0};
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_output();
    pix_out_t want;
    int       row_idx;
    int       issued;
    int       lane_errs;
    assert (exp_q.size() > 0) else begin
      $display("unexpected out_valid at %0d ns with no vector in flight", $time);
      errors++;
    end
    if (exp_q.size() > 0) begin
      want      = exp_q.pop_front();
      row_idx   = row_q.pop_front();
      issued    = issue_q.pop_front();
      lane_errs = 0;
      assert (cycle_count == issued + PIPE_LAT) else begin
        $display("error %0d ns out_valid cycle expected %0d got %0d",
                 $time, issued + PIPE_LAT, cycle_count);
        lane_errs++;
      end
      for (int i = 0; i < N_LANES; i++) begin
        assert (out_data.pix[i] == want.pix[i]) else begin
          $display("error %0d ns out_data.pix[%0d] expected %0d got %0d",
                   $time, i, $signed(want.pix[i]), $signed(out_data.pix[i]));
          lane_errs++;
        end
      end
      lanes_checked += N_LANES;
      rows_checked++;
      errors += lane_errs;
      $display("row %2d mode %0d shift %2d: %s", row_idx, stim_table[row_idx].mode,
               stim_table[row_idx].shift, (lane_errs == 0) ? "ok" : "mismatch");
    end
  endtask

  // outputs settle after the rising edge, look at them on the falling one
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      check_output();
    end
  end

  // cycle counter doubles as the watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [SUM_BUS_W-1:0] sum_vec;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    load_table();

    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    for (int r = 0; r < N_ROWS; r++) begin
      build_vector(stim_table[r], sum_vec);
      in_data.mode       = stim_table[r].mode;
      in_data.e_set[0]   = stim_table[r].e_lo;
      in_data.e_set[1]   = stim_table[r].e_hi;
      in_data.shift      = stim_table[r].shift;
      in_data.sum_vector = sum_vec;
      in_valid           = 1'b1;
      exp_q.push_back(expect_pixels(stim_table[r]));
      row_q.push_back(r);
      issue_q.push_back(cycle_count);
      @(negedge clk);
      // idle cycles between some rows
      if (stim_table[r].gap != 2'd0) begin
        in_valid = 1'b0;
        repeat (int'(stim_table[r].gap)) @(negedge clk);
      end
    end
    in_valid = 1'b0;

    // last row leaves the pipe PIPE_LAT cycles after it went in
    // extra cycles catch stray strobes
    repeat (PIPE_LAT + 4) @(negedge clk);

    assert (rows_checked == N_ROWS) else begin
      $display("only %0d of %0d rows produced an output", rows_checked, N_ROWS);
      errors++;
    end

    $display("summary: %0d rows, %0d lanes checked, %0d errors",
             rows_checked, lanes_checked, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
